// File: compile.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/decode_registers.sv
hdl/execute_stage.sv
hdl/decode_execute_top.sv
tb/decode_execute_tb.sv

// File: hdl/control_unit.sv
//##########################################################
// Control unit
// Decodes ADD, SUB, AND, OR and ADDI into control signals,
// register indices and a sign-extended immediate
//##########################################################

`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module control_unit (
    input  isa_pkg::instr_t instr,
    input  logic instr_valid,
    output pipe_pkg::ctrl_t ctrl,
    output isa_pkg::reg_index_t dest,
    output isa_pkg::reg_index_t src1,
    output isa_pkg::reg_index_t src2,
    output isa_pkg::word_t imm
);

    isa_pkg::opcode_t opcode;
    isa_pkg::funct3_t funct3;
    isa_pkg::funct7_t funct7;
    logic [`IMM_WIDTH-1:0] imm_field;
    logic known;
    logic is_imm;
    pipe_pkg::alu_op_t alu_op;

    // Field extraction
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_field = instr[31:20];
    assign dest = instr[11:7];
    assign src1 = instr[19:15];
    // I-type has no second source, so no forwarding match either
    assign src2 = is_imm ? '0 : instr[24:20];

    // Sign extension of the 12-bit immediate
    assign imm = {{(`WORD_WIDTH - `IMM_WIDTH){imm_field[`IMM_WIDTH-1]}}, imm_field};

    always_comb
    begin
        known = 1'b0;
        is_imm = 1'b0;
        alu_op = pipe_pkg::ALU_ADD;
        case (opcode)
            isa_pkg::OPCODE_OP:
            begin
                // R-type, funct7 picks ADD or SUB
                if (funct3 == isa_pkg::FUNCT3_ADD_SUB && funct7 == isa_pkg::FUNCT7_BASE)
                begin
                    known = 1'b1;
                end
                else if (funct3 == isa_pkg::FUNCT3_ADD_SUB && funct7 == isa_pkg::FUNCT7_SUB)
                begin
                    known = 1'b1;
                    alu_op = pipe_pkg::ALU_SUB;
                end
                else if (funct3 == isa_pkg::FUNCT3_AND && funct7 == isa_pkg::FUNCT7_BASE)
                begin
                    known = 1'b1;
                    alu_op = pipe_pkg::ALU_AND;
                end
                else if (funct3 == isa_pkg::FUNCT3_OR && funct7 == isa_pkg::FUNCT7_BASE)
                begin
                    known = 1'b1;
                    alu_op = pipe_pkg::ALU_OR;
                end
            end
            isa_pkg::OPCODE_OP_IMM:
            begin
                // Only ADDI from the immediate group
                if (funct3 == isa_pkg::FUNCT3_ADD_SUB)
                begin
                    known = 1'b1;
                    is_imm = 1'b1;
                end
            end
            default:
            begin
                known = 1'b0;
            end
        endcase
    end

    // Bubble for unknown encodings, invalid slots and writes to x0
    assign ctrl = '{reg_write: known && instr_valid && (dest != '0),
                    alu_src_imm: is_imm,
                    alu_op: alu_op};

endmodule

`default_nettype wire

// File: hdl/core_cfg.svh
//##########################################################
// Core configuration
// Word, register file and immediate sizes shared by the
// decode and execute pipeline
//##########################################################

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data and instruction word width
`define WORD_WIDTH 32

// Number of architectural registers
`define REG_COUNT 32

// Bits needed to name one register
`define REG_INDEX_WIDTH 5

// I-type immediate field, before sign extension
`define IMM_WIDTH 12

`endif

// File: hdl/decode_execute_top.sv
//##########################################################
// Decode/execute top
// Decoder, register file, pipeline register and execute
// stage of the integer pipeline
//##########################################################

`timescale 1ns/1ns
`default_nettype none

module decode_execute_top (
    input  logic clk,
    input  logic reset,
    input  isa_pkg::instr_t instr,
    input  logic instr_valid,
    input  logic stall,
    output pipe_pkg::wb_t wb
);

    // Decode side
    pipe_pkg::ctrl_t ctrl;
    isa_pkg::reg_index_t dest;
    isa_pkg::reg_index_t src1;
    isa_pkg::reg_index_t src2;
    isa_pkg::word_t imm;
    isa_pkg::word_t rs1_value;
    isa_pkg::word_t rs2_value;
    pipe_pkg::decode_bundle_t bundle_in;
    pipe_pkg::decode_bundle_t bundle_out;

    // Write-back into the register file
    logic write_enable;
    isa_pkg::reg_index_t write_dest;
    isa_pkg::word_t write_data;

    control_unit control_unit_i (
        .instr       (instr),
        .instr_valid (instr_valid),
        .ctrl        (ctrl),
        .dest        (dest),
        .src1        (src1),
        .src2        (src2),
        .imm         (imm)
    );

    register_file register_file_i (
        .clk          (clk),
        .reset        (reset),
        .src1         (src1),
        .src2         (src2),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .write_enable (write_enable),
        .write_dest   (write_dest),
        .write_data   (write_data)
    );

    // Bundle for the pipeline register
    assign bundle_in = '{ctrl: ctrl, dest: dest, src1: src1, src2: src2,
                         rs1_value: rs1_value, rs2_value: rs2_value, imm: imm};

    decode_registers decode_registers_i (
        .clk        (clk),
        .reset      (reset),
        .stall      (stall),
        .bundle_in  (bundle_in),
        .bundle_out (bundle_out)
    );

    execute_stage execute_stage_i (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .bundle       (bundle_out),
        .write_enable (write_enable),
        .write_dest   (write_dest),
        .write_data   (write_data),
        .wb           (wb)
    );

endmodule

`default_nettype wire

// File: hdl/decode_registers.sv
//##########################################################
// Decode registers
// Pipeline register between decode and execute, frozen
// while stall is high
//##########################################################

`timescale 1ns/1ns
`default_nettype none

module decode_registers (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  pipe_pkg::decode_bundle_t bundle_in,
    output pipe_pkg::decode_bundle_t bundle_out
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Bubble after reset, operand payload left as is
            bundle_out.ctrl <= '0;
        end
        else if (!stall)
        begin
            // Invalid slots arrive with reg_write already low
            bundle_out <= bundle_in;
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
//##########################################################
// Execute stage
// Operand forwarding, ALU, register file write request
// and the registered write-back record
//##########################################################

`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  pipe_pkg::decode_bundle_t bundle,
    output logic write_enable,
    output isa_pkg::reg_index_t write_dest,
    output isa_pkg::word_t write_data,
    output pipe_pkg::wb_t wb
);

    // Last instruction that wrote a register
    logic fwd_valid;
    isa_pkg::reg_index_t fwd_dest;
    isa_pkg::word_t fwd_data;

    isa_pkg::word_t operand_a;
    isa_pkg::word_t rs2_forwarded;
    isa_pkg::word_t operand_b;
    isa_pkg::word_t alu_result;

    // Operands were read one cycle early, so the last write may be missing
    assign operand_a = (fwd_valid && (fwd_dest != '0) && (fwd_dest == bundle.src1))
                       ? fwd_data : bundle.rs1_value;
    assign rs2_forwarded = (fwd_valid && (fwd_dest != '0) && (fwd_dest == bundle.src2))
                           ? fwd_data : bundle.rs2_value;

    // Immediate or register for the second operand
    assign operand_b = bundle.ctrl.alu_src_imm ? bundle.imm : rs2_forwarded;

    always_comb
    begin
        case (bundle.ctrl.alu_op)
            pipe_pkg::ALU_ADD: alu_result = operand_a + operand_b;
            pipe_pkg::ALU_SUB: alu_result = operand_a - operand_b;
            pipe_pkg::ALU_AND: alu_result = operand_a & operand_b;
            pipe_pkg::ALU_OR:  alu_result = operand_a | operand_b;
            default:           alu_result = operand_a + operand_b;
        endcase
    end

    // Write request, suppressed while frozen
    assign write_enable = bundle.ctrl.reg_write && !stall;
    assign write_dest = bundle.dest;
    assign write_data = alu_result;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fwd_valid <= 1'b0;
        end
        else if (write_enable)
        begin
            fwd_valid <= 1'b1;
            fwd_dest <= write_dest;
            fwd_data <= write_data;
        end
    end

    // One-cycle valid pulse per executed write
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb.valid <= 1'b0;
        end
        else
        begin
            wb.valid <= write_enable;
            if (write_enable)
            begin
                wb.dest <= write_dest;
                wb.data <= write_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/isa_pkg.sv
//##########################################################
// ISA package
// Instruction, register and data word types, and the
// encodings of the supported RV32I subset
//##########################################################

`default_nettype none

`include "core_cfg.svh"

package isa_pkg;

    // Basic words
    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`WORD_WIDTH-1:0] instr_t;
    typedef logic [`REG_INDEX_WIDTH-1:0] reg_index_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Register-register arithmetic
    localparam opcode_t OPCODE_OP = 7'b0110011;
    // Register-immediate arithmetic
    localparam opcode_t OPCODE_OP_IMM = 7'b0010011;

    // Shared by ADD, SUB and ADDI
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_AND = 3'b111;
    localparam funct3_t FUNCT3_OR = 3'b110;

    // Plain R-type operation
    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    // Turns ADD into SUB
    localparam funct7_t FUNCT7_SUB = 7'b0100000;

endpackage

`default_nettype wire

// File: hdl/pipe_pkg.sv
//##########################################################
// Pipeline package
// Control bundle, ALU operations, decode bundle and
// write-back record passed between pipeline stages
//##########################################################

`default_nettype none

package pipe_pkg;

    // ALU operation select
    typedef logic [1:0] alu_op_t;

    localparam alu_op_t ALU_ADD = 2'd0;
    localparam alu_op_t ALU_SUB = 2'd1;
    localparam alu_op_t ALU_AND = 2'd2;
    localparam alu_op_t ALU_OR = 2'd3;

    // Control signals from the decoder
    typedef struct packed {
        logic reg_write;
        logic alu_src_imm;
        alu_op_t alu_op;
    } ctrl_t;

    // Everything execute needs from decode
    typedef struct packed {
        ctrl_t ctrl;
        isa_pkg::reg_index_t dest;
        isa_pkg::reg_index_t src1;
        isa_pkg::reg_index_t src2;
        isa_pkg::word_t rs1_value;
        isa_pkg::word_t rs2_value;
        isa_pkg::word_t imm;
    } decode_bundle_t;

    // Result of one instruction leaving the pipeline
    typedef struct packed {
        logic valid;
        isa_pkg::reg_index_t dest;
        isa_pkg::word_t data;
    } wb_t;

endpackage

`default_nettype wire

// File: hdl/register_file.sv
//##########################################################
// Register file
// 32 registers, two combinational reads, one write port,
// register zero hardwired to zero
//##########################################################

`timescale 1ns/1ns
`default_nettype none

`include "core_cfg.svh"

module register_file (
    input  logic clk,
    input  logic reset,
    input  isa_pkg::reg_index_t src1,
    input  isa_pkg::reg_index_t src2,
    output isa_pkg::word_t rs1_value,
    output isa_pkg::word_t rs2_value,
    input  logic write_enable,
    input  isa_pkg::reg_index_t write_dest,
    input  isa_pkg::word_t write_data
);

    // No storage behind x0
    isa_pkg::word_t regs [1:`REG_COUNT-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // Architectural state starts at zero
            for (int i = 1; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (write_enable && (write_dest != '0))
        begin
            regs[write_dest] <= write_data;
        end
    end

    // Reads see the old value during a same-cycle write
    assign rs1_value = (src1 == '0) ? '0 : regs[src1];
    assign rs2_value = (src2 == '0) ? '0 : regs[src2];

endmodule

`default_nettype wire

// File: tb/decode_execute_tb.sv
//##########################################################
// Decode/execute testbench
// Directed tests against a reference register model,
// covering forwarding, bubbles and stall
//##########################################################

`timescale 1ns/1ns
`default_nettype none

module decode_execute_tb;

    localparam int PERIOD = 100;
    // Reset plus all tests take 62 cycles
    localparam int TEST_CYCLES = 62;
    localparam int MARGIN_CYCLES = 30;

    // Operations of the reference model
    localparam int OP_ADD = 0;
    localparam int OP_SUB = 1;
    localparam int OP_AND = 2;
    localparam int OP_OR = 3;
    localparam int OP_ADDI = 4;

    logic clk;
    logic reset;
    isa_pkg::instr_t instr;
    logic instr_valid;
    logic stall;
    pipe_pkg::wb_t wb;

    // Register state the tests expect
    isa_pkg::word_t model [0:31];
    logic [15:0] lfsr;

    // Write-back due at the next falling edge
    logic exp_valid;
    isa_pkg::reg_index_t exp_dest;
    isa_pkg::word_t exp_data;

    decode_execute_top decode_execute_top_i (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .wb          (wb)
    );

    always #(PERIOD / 2) clk = ~clk;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // RV32I encodings of the subset
    function automatic isa_pkg::instr_t encode(input int op, input int rd, input int rs1,
                                               input int rs2, input logic [11:0] imm);
        case (op)
            OP_SUB: return {7'b0100000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
            OP_AND: return {7'b0000000, 5'(rs2), 5'(rs1), 3'b111, 5'(rd), 7'b0110011};
            OP_OR: return {7'b0000000, 5'(rs2), 5'(rs1), 3'b110, 5'(rd), 7'b0110011};
            OP_ADDI: return {imm, 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
            default: return {7'b0000000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Offer one word for a cycle, then check the result of the word before it
    task automatic send(input isa_pkg::instr_t word, input logic valid, input logic next_valid,
                        input int next_dest, input isa_pkg::word_t next_data);
        instr = word;
        instr_valid = valid;
        stall = 1'b0;
        @(negedge clk);
        check_value("wb.valid", 32'(wb.valid), 32'(exp_valid));
        if (exp_valid)
        begin
            check_value("wb.dest", 32'(wb.dest), 32'(exp_dest));
            check_value("wb.data", wb.data, exp_data);
        end
        exp_valid = next_valid;
        exp_dest = 5'(next_dest);
        exp_data = next_data;
    endtask

    // Valid instruction with its result from the model
    task automatic issue(input int op, input int rd, input int rs1, input int rs2,
                         input logic [11:0] imm);
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t result;
        a = model[rs1];
        b = (op == OP_ADDI) ? {{20{imm[11]}}, imm} : model[rs2];
        case (op)
            OP_SUB: result = a - b;
            OP_AND: result = a & b;
            OP_OR: result = a | b;
            default: result = a + b;
        endcase
        // x0 keeps zero and never reports a write
        if (rd != 0)
        begin
            model[rd] = result;
        end
        send(encode(op, rd, rs1, rs2, imm), 1'b1, rd != 0, rd, result);
    endtask

    // Word that must not write anything
    task automatic bubble(input isa_pkg::instr_t word, input logic valid);
        send(word, valid, 1'b0, 0, '0);
    endtask

    task automatic test_reset_state();
        check_value("wb.valid", 32'(wb.valid), 32'd0);
        for (int i = 0; i < 4; i++)
        begin
            issue(OP_ADD, 1 + random_bits(4), 1 + random_bits(4), 16 + random_bits(4), '0);
        end
        issue(OP_ADDI, 30, 31, 0, 12'h000);
        bubble('0, 1'b0);
    endtask

    task automatic test_arithmetic();
        logic [11:0] imm;
        for (int r = 1; r <= 8; r++)
        begin
            imm = 12'(random_bits(12));
            // Odd registers get negative values
            if (r % 2 == 1)
            begin
                imm[11] = 1'b1;
            end
            issue(OP_ADDI, r, 0, 0, imm);
        end
        for (int i = 0; i < 12; i++)
        begin
            issue(i % 4, 9 + random_bits(3), 1 + random_bits(3), 1 + random_bits(3), '0);
        end
        // ADDI on a nonzero base
        issue(OP_ADDI, 9 + random_bits(3), 1 + random_bits(3), 0, 12'(random_bits(12)));
        issue(OP_ADDI, 9 + random_bits(3), 1 + random_bits(3), 0, 12'(random_bits(12)));
        bubble('0, 1'b0);
    endtask

    task automatic test_forwarding();
        int prev;
        int dest;
        int other;
        int op;
        prev = 10;
        issue(OP_ADDI, prev, 1, 0, 12'(random_bits(12)));
        // Each result feeds the next instruction directly
        for (int i = 0; i < 8; i++)
        begin
            dest = 10 + random_bits(3);
            other = 1 + random_bits(3);
            op = random_bits(2);
            if (random_bits(1))
            begin
                issue(op, dest, prev, other, '0);
            end
            else
            begin
                issue(op, dest, other, prev, '0);
            end
            prev = dest;
        end
        issue(OP_ADDI, 18, prev, 0, 12'(random_bits(12)));
        bubble('0, 1'b0);
    endtask

    task automatic test_no_write();
        issue(OP_ADDI, 0, 3, 0, 12'h7ff);
        issue(OP_ADD, 0, 1, 2, '0);
        // LUI opcode is outside the subset
        bubble({20'h12345, 5'd5, 7'b0110111}, 1'b1);
        // SUB marker on AND is not a real encoding
        bubble({7'b0100000, 5'd2, 5'd1, 3'b111, 5'd6, 7'b0110011}, 1'b1);
        bubble(encode(OP_ADDI, 7, 0, 0, 12'h123), 1'b0);
        // x0 still zero, x5 to x7 untouched
        issue(OP_ADD, 20, 0, 0, '0);
        issue(OP_OR, 21, 0, 5, '0);
        issue(OP_ADDI, 22, 6, 0, 12'h000);
        issue(OP_ADD, 23, 7, 0, '0);
        bubble('0, 1'b0);
    endtask

    task automatic test_stall();
        isa_pkg::instr_t held;
        issue(OP_ADDI, 24, 0, 0, 12'(random_bits(12)));
        held = encode(OP_ADD, 25, 24, 3, '0);
        // Dependent ADD waits on the input while the pipeline is frozen
        for (int i = 0; i < 4; i++)
        begin
            instr = held;
            instr_valid = 1'b1;
            stall = 1'b1;
            @(negedge clk);
            check_value("wb.valid", 32'(wb.valid), 32'd0);
        end
        // ADDI retires once, then the chain continues through forwarding
        issue(OP_ADD, 25, 24, 3, '0);
        issue(OP_SUB, 26, 25, 24, '0);
        issue(OP_OR, 27, 26, 26, '0);
        bubble('0, 1'b0);
        bubble('0, 1'b0);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        instr = '0;
        instr_valid = 1'b0;
        stall = 1'b0;
        lfsr = 16'd40;
        exp_valid = 1'b0;
        exp_dest = '0;
        exp_data = '0;
        for (int i = 0; i < 32; i++)
        begin
            model[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_arithmetic();
        test_forwarding();
        test_no_write();
        test_stall();
        $display("Everything OK");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((TEST_CYCLES + MARGIN_CYCLES) * PERIOD);
        $display("Timeout, tests still running after %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
        $display("Something failed");
        $fatal(1);
    end

endmodule

`default_nettype wire
